//--- common/simf_macros.svh
`ifndef SIMF_MACROS_SVH
`define SIMF_MACROS_SVH

// Single precision word layout
`define SIMF_DATA_W    32
`define SIMF_MANT_W    24 // Hidden bit included
`define SIMF_EXP_W     8
`define SIMF_EXP_BIAS  127

// Encoding format codes, control word bits 31:24
`define SIMF_FMT_VOP1  8'h01
`define SIMF_FMT_VOP2  8'h02
`define SIMF_FMT_VOPC  8'h04
`define SIMF_FMT_VOP3A 8'h08
`define SIMF_FMT_VOP3B 8'h10

`endif

//--- common/simf_isa_pkg.sv
package simf_isa_pkg;

`include "simf_macros.svh"

   typedef logic [`SIMF_DATA_W-1:0] data_t;
   typedef logic [11:0] opc_t; // Opcode field, control word bits 11:0

   typedef enum logic [7:0] {
      FMT_VOP1  = `SIMF_FMT_VOP1,
      FMT_VOP2  = `SIMF_FMT_VOP2,
      FMT_VOPC  = `SIMF_FMT_VOPC,
      FMT_VOP3A = `SIMF_FMT_VOP3A,
      FMT_VOP3B = `SIMF_FMT_VOP3B
   } fmt_e;

   typedef enum logic [11:0] {
      OPC_CMP_F   = 12'h000,
      OPC_CMP_LT  = 12'h001,
      OPC_CMP_EQ  = 12'h002,
      OPC_CMP_LE  = 12'h003,
      OPC_CMP_GT  = 12'h004,
      OPC_CMP_LG  = 12'h005,
      OPC_CMP_GE  = 12'h006,
      OPC_MUL     = 12'h008, // VOP2 encoding
      OPC_CMP_NGE = 12'h009,
      OPC_CMP_NLG = 12'h00A,
      OPC_CMP_NGT = 12'h00B,
      OPC_CMP_NLE = 12'h00C,
      OPC_CMP_NEQ = 12'h00D,
      OPC_CMP_NLT = 12'h00E,
      OPC_CMP_TRU = 12'h00F,
      OPC_MAX     = 12'h010,
      OPC_MUL3    = 12'h108  // VOP3A encoding
   } opc_e;

endpackage

//--- common/simf_fp_pkg.sv
package simf_fp_pkg;

`include "simf_macros.svh"

   // Float fields
   typedef logic [`SIMF_EXP_W-1:0]    exp_t;
   typedef logic [`SIMF_MANT_W-1:0]   mant_t;
   typedef logic [2*`SIMF_MANT_W-1:0] prod_t;

   // One step per multiplier bit, 0 to 23
   typedef logic [4:0] step_t;

   typedef enum logic [1:0] {
      FMUL_IDLE = 2'd0,
      FMUL_STEP = 2'd1, // Shift-add over the mantissa bits
      FMUL_NORM = 2'd2
   } fmul_state_e;

endpackage

//--- common/simf_mul_if.sv
`timescale 1ns/1ns

interface simf_mul_if
   import simf_isa_pkg::*;
   ();

   logic  start; // One cycle pulse
   data_t opa;
   data_t opb;
   data_t result;
   logic  ready; // Level, held until next start

   modport req (
      output start, opa, opb,
      input  result, ready
   );

   modport ctrl (
      input  start,
      output ready
   );

   modport data (
      input  opa, opb,
      output result
   );

endinterface

//--- logic/simf_op_decode.sv
`timescale 1ns/1ns

module simf_op_decode
   import simf_isa_pkg::*;
(
   input  data_t          src1_i,
   input  data_t          src2_i,
   input  logic           vcc_i,
   input  logic           exec_i,
   input  logic           start_i,
   input  logic [31:0]    control_i,
   simf_mul_if.req        mul,
   output data_t          vgpr_o,
   output logic           vcc_o,
   output logic           sgpr_o,
   output logic           done_o
);

   fmt_e fmt;
   opc_t opc;
   logic lt, eq, gt;
   logic cmp_hit;
   logic cmp_res;
   logic is_cmp, is_max, is_mul;

   assign fmt = fmt_e'(control_i[31:24]);
   assign opc = control_i[11:0];

   // Raw unsigned bit compare, no float ordering
   assign lt = (src1_i < src2_i);
   assign eq = (src1_i == src2_i);
   assign gt = (src1_i > src2_i);

   always_comb
   begin
      cmp_hit = 1'b1;
      cmp_res = 1'b0;
      case (opc)
         OPC_CMP_F   : cmp_res = 1'b0;
         OPC_CMP_LT  : cmp_res = lt;
         OPC_CMP_EQ  : cmp_res = eq;
         OPC_CMP_LE  : cmp_res = lt | eq;
         OPC_CMP_GT  : cmp_res = gt;
         OPC_CMP_LG  : cmp_res = !eq;
         OPC_CMP_GE  : cmp_res = !lt;
         OPC_CMP_NGE : cmp_res = lt;
         OPC_CMP_NLG : cmp_res = eq;
         OPC_CMP_NGT : cmp_res = !gt;
         OPC_CMP_NLE : cmp_res = gt;
         OPC_CMP_NEQ : cmp_res = !eq;
         OPC_CMP_NLT : cmp_res = !lt;
         OPC_CMP_TRU : cmp_res = 1'b1;
         default     : cmp_hit = 1'b0;
      endcase
   end

   assign is_cmp = cmp_hit && (fmt == FMT_VOPC || fmt == FMT_VOP3A);
   assign is_max = (fmt == FMT_VOP2) && (opc == OPC_MAX);
   assign is_mul = ((fmt == FMT_VOP2) && (opc == OPC_MUL)) ||
                   ((fmt == FMT_VOP3A) && (opc == OPC_MUL3));

   // Sources go straight to the multiplier
   assign mul.opa = src1_i;
   assign mul.opb = src2_i;

   always_comb
   begin
      mul.start = 1'b0;
      done_o    = 1'b1; // Exec off and unknown ops finish at once
      vgpr_o    = '0;
      vcc_o     = vcc_i;
      if (exec_i)
      begin
         if (is_cmp)
            vcc_o = cmp_res;
         else if (is_max)
            vgpr_o = (src1_i >= src2_i) ? src1_i : src2_i;
         else if (is_mul)
         begin
            mul.start = start_i;
            done_o    = mul.ready;
            vgpr_o    = mul.result;
         end
      end
   end

   assign sgpr_o = vcc_o;

endmodule

//--- fmul/simf_fmul_ctrl.sv
`timescale 1ns/1ns

module simf_fmul_ctrl
   import simf_fp_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n_i,
   simf_mul_if.ctrl mul,
   input  logic    step_last_i,
   output logic    load_o,
   output logic    step_o,
   output logic    norm_o,
   output logic    cnt_clr_o,
   output logic    cnt_en_o
);

   fmul_state_e state_q, state_d;
   logic        ready_q;

   always_comb
   begin
      state_d   = state_q;
      load_o    = 1'b0;
      step_o    = 1'b0;
      norm_o    = 1'b0;
      cnt_clr_o = 1'b0;
      cnt_en_o  = 1'b0;
      case (state_q)
         FMUL_IDLE :
            if (mul.start)
            begin
               load_o    = 1'b1; // Latch operands
               cnt_clr_o = 1'b1;
               state_d   = FMUL_STEP;
            end
         FMUL_STEP :
         begin
            step_o   = 1'b1;
            cnt_en_o = !step_last_i; // Counter parks on the last bit
            if (step_last_i)
               state_d = FMUL_NORM;
         end
         FMUL_NORM :
         begin
            norm_o  = 1'b1;
            state_d = FMUL_IDLE;
         end
         default : state_d = FMUL_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q <= FMUL_IDLE;
         ready_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (load_o)
            ready_q <= 1'b0; // Cleared by a new start
         else if (norm_o)
            ready_q <= 1'b1;
      end
   end

   assign mul.ready = ready_q;

   // Decoder must hold off until ready
   start_idle_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      mul.start |-> state_q == FMUL_IDLE)
      else $error("multiply start while busy");

endmodule

//--- fmul/simf_fmul_step_cnt.sv
`timescale 1ns/1ns

`include "simf_macros.svh"

module simf_fmul_step_cnt
   import simf_fp_pkg::*;
(
   input  logic clk,
   input  logic arst_n_i,
   input  logic clr_i,
   input  logic en_i,
   output logic step_last_o
);

   step_t cnt_q;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         cnt_q <= '0;
      else if (clr_i)
         cnt_q <= '0;
      else if (en_i)
         cnt_q <= cnt_q + step_t'(1);
   end

   assign step_last_o = (cnt_q == step_t'(`SIMF_MANT_W-1)); // Top mantissa bit

   cnt_range_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      cnt_q <= step_t'(`SIMF_MANT_W-1))
      else $error("step count past last mantissa bit");

endmodule

//--- fmul/simf_fmul_datapath.sv
`timescale 1ns/1ns

`include "simf_macros.svh"

module simf_fmul_datapath
   import simf_isa_pkg::*;
   import simf_fp_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n_i,
   simf_mul_if.data mul,
   input  logic    load_i,
   input  logic    step_i,
   input  logic    norm_i
);

   exp_t  exp_a, exp_b;
   logic  sign_q;
   logic  zero_q, inf_q;
   logic signed [`SIMF_EXP_W+1:0] exp_q, exp_n; // Room for over and underflow
   prod_t mcand_q;
   prod_t prod_q;
   mant_t mplier_q;
   logic [`SIMF_MANT_W-2:0] frac_n;
   data_t res_d, res_q;

   assign exp_a = mul.opa[`SIMF_DATA_W-2 -: `SIMF_EXP_W];
   assign exp_b = mul.opb[`SIMF_DATA_W-2 -: `SIMF_EXP_W];

   always_ff @(posedge clk)
   begin
      if (load_i)
      begin
         sign_q   <= mul.opa[`SIMF_DATA_W-1] ^ mul.opb[`SIMF_DATA_W-1];
         exp_q    <= {2'b00, exp_a} + {2'b00, exp_b} - 10'(`SIMF_EXP_BIAS);
         zero_q   <= (exp_a == '0) || (exp_b == '0); // Denormals flush here
         inf_q    <= (exp_a == '1) || (exp_b == '1); // NaN taken as inf
         mcand_q  <= prod_t'({1'b1, mul.opa[`SIMF_MANT_W-2:0]});
         mplier_q <= {1'b1, mul.opb[`SIMF_MANT_W-2:0]};
         prod_q   <= '0;
      end
      else if (step_i)
      begin
         if (mplier_q[0])
            prod_q <= prod_q + mcand_q;
         mcand_q  <= mcand_q << 1;
         mplier_q <= mplier_q >> 1;
      end
   end

   always_comb
   begin
      // Product is in [1,4), at most one shift
      if (prod_q[2*`SIMF_MANT_W-1])
      begin
         frac_n = prod_q[2*`SIMF_MANT_W-2 -: `SIMF_MANT_W-1];
         exp_n  = exp_q + 10'sd1;
      end
      else
      begin
         frac_n = prod_q[2*`SIMF_MANT_W-3 -: `SIMF_MANT_W-1];
         exp_n  = exp_q;
      end

      // Truncation gives round toward zero
      if (zero_q)
         res_d = {sign_q, {(`SIMF_DATA_W-1){1'b0}}};
      else if (inf_q || exp_n >= 10'sd255)
         res_d = {sign_q, {`SIMF_EXP_W{1'b1}}, {(`SIMF_MANT_W-1){1'b0}}};
      else if (exp_n <= 10'sd0)
         res_d = {sign_q, {(`SIMF_DATA_W-1){1'b0}}};
      else
         res_d = {sign_q, exp_n[`SIMF_EXP_W-1:0], frac_n};
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         res_q <= '0;
      else if (norm_i)
         res_q <= res_d; // Held until the next normalize
   end

   assign mul.result = res_q;

endmodule

//--- logic/simf_alu.sv
`timescale 1ns/1ns

`include "simf_macros.svh"

module simf_alu
   import simf_isa_pkg::*;
(
   input  logic                    clk,
   input  logic                    arst_n_i,
   input  data_t                   alu_source1_data_i,
   input  data_t                   alu_source2_data_i,
   input  logic                    alu_source_vcc_value_i,
   input  logic                    alu_source_exec_value_i,
   input  logic [`SIMF_DATA_W-1:0] alu_control_i,
   input  logic                    alu_start_i,
   output data_t                   alu_vgpr_dest_data_o,
   output logic                    alu_sgpr_dest_data_o,
   output logic                    alu_dest_vcc_value_o,
   output logic                    alu_done_o
);

   logic load, step, norm;
   logic cnt_clr, cnt_en, step_last;

   simf_mul_if mul_if ();

   simf_op_decode u_decode (
      .src1_i    (alu_source1_data_i),
      .src2_i    (alu_source2_data_i),
      .vcc_i     (alu_source_vcc_value_i),
      .exec_i    (alu_source_exec_value_i),
      .start_i   (alu_start_i),
      .control_i (alu_control_i),
      .mul       (mul_if.req),
      .vgpr_o    (alu_vgpr_dest_data_o),
      .vcc_o     (alu_dest_vcc_value_o),
      .sgpr_o    (alu_sgpr_dest_data_o),
      .done_o    (alu_done_o)
   );

   simf_fmul_ctrl u_fmul_ctrl (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .mul         (mul_if.ctrl),
      .step_last_i (step_last),
      .load_o      (load),
      .step_o      (step),
      .norm_o      (norm),
      .cnt_clr_o   (cnt_clr),
      .cnt_en_o    (cnt_en)
   );

   simf_fmul_step_cnt u_fmul_cnt (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .clr_i       (cnt_clr),
      .en_i        (cnt_en),
      .step_last_o (step_last)
   );

   simf_fmul_datapath u_fmul_dp (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .mul      (mul_if.data),
      .load_i   (load),
      .step_i   (step),
      .norm_i   (norm)
   );

endmodule

//--- dv/simf_alu_tb.sv
`timescale 1ns/1ns

`include "simf_macros.svh"

module simf_alu_tb
   import simf_isa_pkg::*;
();

   localparam int DONE_LIMIT = 40; // Edges allowed for done after the busy window

   logic        clk;
   logic        arst_n_i;
   data_t       src1, src2, vgpr, exp_vgpr;
   logic        vcc_in, exec_in, start, sgpr, vcc_out, done, exp_vcc;
   logic [31:0] control;
   logic        chk_cmp, chk_max, chk_off, chk_busy, chk_mul;
   opc_t        cmp_list [14];
   integer      seed;
   int          errors, timeouts, vectors;

   simf_alu UUT (
      .clk                     (clk),
      .arst_n_i                (arst_n_i),
      .alu_source1_data_i      (src1),
      .alu_source2_data_i      (src2),
      .alu_source_vcc_value_i  (vcc_in),
      .alu_source_exec_value_i (exec_in),
      .alu_control_i           (control),
      .alu_start_i             (start),
      .alu_vgpr_dest_data_o    (vgpr),
      .alu_sgpr_dest_data_o    (sgpr),
      .alu_dest_vcc_value_o    (vcc_out),
      .alu_done_o              (done)
   );

   always #2 clk = ~clk;

   // Compares act on raw unsigned bits
   function automatic logic cmp_model(opc_t opc, data_t a, data_t b);
      case (opc)
         OPC_CMP_LT  : cmp_model = (a < b);
         OPC_CMP_EQ  : cmp_model = (a == b);
         OPC_CMP_LE  : cmp_model = (a <= b);
         OPC_CMP_GT  : cmp_model = (a > b);
         OPC_CMP_LG  : cmp_model = (a != b);
         OPC_CMP_GE  : cmp_model = (a >= b);
         OPC_CMP_NGE : cmp_model = !(a >= b);
         OPC_CMP_NLG : cmp_model = (a == b);
         OPC_CMP_NGT : cmp_model = !(a > b);
         OPC_CMP_NLE : cmp_model = !(a <= b);
         OPC_CMP_NEQ : cmp_model = (a != b);
         OPC_CMP_NLT : cmp_model = !(a < b);
         OPC_CMP_TRU : cmp_model = 1'b1;
         default     : cmp_model = 1'b0; // Also F
      endcase
   endfunction

   function automatic data_t fmul_model(data_t a, data_t b);
      logic        sign;
      int          ea, eb, e;
      logic [47:0] p;
      logic [22:0] frac;
      sign = a[31] ^ b[31];
      ea   = a[30:23];
      eb   = b[30:23];
      if (ea == 0 || eb == 0)
         return {sign, 31'd0}; // Zero and denormals
      if (ea == 255 || eb == 255)
         return {sign, 8'hff, 23'd0}; // Inf and NaN
      p = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
      e = ea + eb - `SIMF_EXP_BIAS;
      if (p[47])
      begin
         frac = p[46:24];
         e    = e + 1;
      end
      else
         frac = p[45:23];
      if (e >= 255)
         return {sign, 8'hff, 23'd0};
      if (e <= 0)
         return {sign, 31'd0};
      return {sign, e[7:0], frac};
   endfunction

   task automatic report_mismatch(string what);
      errors++;
      $display("[FAIL] %0t: %s", $time, what);
   endtask

   cmp_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      chk_cmp |-> done && vcc_out == exp_vcc && sgpr == vcc_out)
      else report_mismatch($sformatf("compare %h got vcc %b sgpr %b done %b, expected vcc %b",
         $sampled(control), $sampled(vcc_out), $sampled(sgpr), $sampled(done), exp_vcc));

   max_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      chk_max |-> done && vgpr == exp_vgpr && vcc_out == vcc_in && sgpr == vcc_out)
      else report_mismatch($sformatf("max got %h vcc %b, expected %h vcc %b",
         $sampled(vgpr), $sampled(vcc_out), exp_vgpr, $sampled(vcc_in)));

   pass_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      chk_off |-> done && vgpr == 32'd0 && vcc_out == vcc_in && sgpr == vcc_out)
      else report_mismatch($sformatf("pass-through %h got %h vcc %b done %b",
         $sampled(control), $sampled(vgpr), $sampled(vcc_out), $sampled(done)));

   busy_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      chk_busy |-> !done)
      else report_mismatch("done high while multiply is not finished");

   mul_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      chk_mul |-> done && vgpr == exp_vgpr)
      else report_mismatch($sformatf("multiply got %h done %b, expected %h",
         $sampled(vgpr), $sampled(done), exp_vgpr));

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic run_compare(fmt_e fmt, opc_t opc, data_t a, data_t b);
      control = {fmt, 12'd0, opc};
      src1    = a;
      src2    = b;
      vcc_in  = $random(seed);
      exp_vcc = cmp_model(opc, a, b);
      chk_cmp = 1'b1;
      next_cycle();
      chk_cmp = 1'b0;
      vectors++;
   endtask

   task automatic run_max(data_t a, data_t b);
      control  = {FMT_VOP2, 12'd0, OPC_MAX};
      src1     = a;
      src2     = b;
      vcc_in   = $random(seed);
      exp_vgpr = (a > b) ? a : b;
      chk_max  = 1'b1;
      next_cycle();
      chk_max  = 1'b0;
      vectors++;
   endtask

   task automatic run_passthru(logic [31:0] ctl, logic exec);
      control = ctl;
      exec_in = exec;
      src1    = $random(seed);
      src2    = $random(seed);
      vcc_in  = $random(seed);
      chk_off = 1'b1;
      next_cycle();
      chk_off = 1'b0;
      exec_in = 1'b1;
      vectors++;
   endtask

   task automatic run_multiply(fmt_e fmt, opc_t opc, data_t a, data_t b);
      int n;
      control  = {fmt, 12'd0, opc};
      src1     = a;
      src2     = b;
      exp_vgpr = fmul_model(a, b);
      start    = 1'b1;
      next_cycle(); // Start edge
      start    = 1'b0;
      chk_busy = 1'b1;
      repeat (25) next_cycle(); // Load, 24 steps, normalize
      chk_busy = 1'b0;
      chk_mul  = 1'b1;
      n = 0;
      while (done !== 1'b1 && n < DONE_LIMIT)
      begin
         next_cycle();
         n++;
      end
      if (done !== 1'b1)
      begin
         timeouts++;
         $display("Timeout: multiply of %h and %h never raised done", a, b);
      end
      repeat (4) // Result must hold while the sources move
      begin
         src1 = $random(seed);
         src2 = $random(seed);
         next_cycle();
      end
      chk_mul = 1'b0;
      vectors++;
   endtask

   initial
   begin
      data_t a, b;
      int    i, f;
      seed     = 32'h9c12417b;
      clk      = 1'b0;
      arst_n_i = 1'b0;
      {src1, src2, vcc_in, exec_in, control, start} = '0;
      {chk_cmp, chk_max, chk_off, chk_busy, chk_mul, exp_vcc, exp_vgpr} = '0;
      {errors, timeouts, vectors} = '0;
      cmp_list = '{OPC_CMP_F, OPC_CMP_LT, OPC_CMP_EQ, OPC_CMP_LE, OPC_CMP_GT, OPC_CMP_LG,
                   OPC_CMP_GE, OPC_CMP_NGE, OPC_CMP_NLG, OPC_CMP_NGT, OPC_CMP_NLE,
                   OPC_CMP_NEQ, OPC_CMP_NLT, OPC_CMP_TRU};
      repeat (3) @(posedge clk);
      #1 arst_n_i = 1'b1;

      // Multiply word but no start yet
      control  = {FMT_VOP2, 12'd0, OPC_MUL};
      exec_in  = 1'b1;
      chk_busy = 1'b1;
      repeat (3) next_cycle();
      chk_busy = 1'b0;

      for (f = 0; f < 2; f++)
         for (i = 0; i < 14; i++)
         begin
            a = $random(seed);
            run_compare(f ? FMT_VOP3A : FMT_VOPC, cmp_list[i], a, $random(seed));
            run_compare(f ? FMT_VOP3A : FMT_VOPC, cmp_list[i], a, a);
            run_compare(f ? FMT_VOP3A : FMT_VOPC, cmp_list[i], a & ~32'd1, a | 32'd1);
            run_compare(f ? FMT_VOP3A : FMT_VOPC, cmp_list[i], a | 32'd1, a & ~32'd1);
         end

      for (i = 0; i < 6; i++)
         run_max($random(seed), $random(seed));
      a = $random(seed);
      run_max(a, a);

      run_passthru({FMT_VOP2, 12'd0, OPC_MUL}, 1'b0);
      run_passthru({FMT_VOPC, 12'd0, OPC_CMP_TRU}, 1'b0);
      run_passthru({FMT_VOP2, 12'd0, OPC_MAX}, 1'b0);
      run_passthru({FMT_VOP1, 12'd0, OPC_CMP_LT}, 1'b1); // Unknown opcodes
      run_passthru({FMT_VOP2, 12'd0, 12'h7ff}, 1'b1);
      run_passthru({FMT_VOP3B, 12'd0, OPC_MUL3}, 1'b1);
      run_passthru({FMT_VOPC, 12'd0, OPC_MAX}, 1'b1);

      run_multiply(FMT_VOP2, OPC_MUL, 32'h3f800000, 32'h3f800000);
      run_multiply(FMT_VOP3A, OPC_MUL3, 32'h3fc00000, 32'hbfc00000);
      run_multiply(FMT_VOP2, OPC_MUL, 32'h7f7fffff, 32'h40000000); // Overflow
      run_multiply(FMT_VOP3A, OPC_MUL3, 32'h00800000, 32'h3f000000); // Underflow
      run_multiply(FMT_VOP2, OPC_MUL, 32'h00000001, 32'h40000000);
      run_multiply(FMT_VOP3A, OPC_MUL3, 32'h7f800000, 32'hbf800000);
      run_multiply(FMT_VOP2, OPC_MUL, 32'h7fc00000, 32'h3f800000);
      run_multiply(FMT_VOP3A, OPC_MUL3, 32'h00000000, 32'h7f800000);
      for (i = 0; i < 8; i++)
      begin
         a = $random(seed);
         b = $random(seed);
         if (i < 5)
         begin
            a[30:23] = 8'd120 + 8'($random(seed) & 15); // Keep exponents in range
            b[30:23] = 8'd120 + 8'($random(seed) & 15);
         end
         run_multiply(i[0] ? FMT_VOP3A : FMT_VOP2, i[0] ? OPC_MUL3 : OPC_MUL, a, b);
      end

      $display("Summary: %0d vectors, %0d errors, %0d timeouts", vectors, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

//--- flist.f
+incdir+common
common/simf_isa_pkg.sv
common/simf_fp_pkg.sv
common/simf_mul_if.sv
logic/simf_op_decode.sv
fmul/simf_fmul_ctrl.sv
fmul/simf_fmul_step_cnt.sv
fmul/simf_fmul_datapath.sv
logic/simf_alu.sv
dv/simf_alu_tb.sv

//--- Bender.yml
package:
  name: simf_alu

export_include_dirs:
  - common

sources:
  - common/simf_isa_pkg.sv
  - common/simf_fp_pkg.sv
  - common/simf_mul_if.sv
  - logic/simf_op_decode.sv
  - fmul/simf_fmul_ctrl.sv
  - fmul/simf_fmul_step_cnt.sv
  - fmul/simf_fmul_datapath.sv
  - logic/simf_alu.sv
  - target: test
    files:
      - dv/simf_alu_tb.sv
